// File: source/complex_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Compute complex shared definitions
// Sizes, control address map, opcodes and the packed
// structs that travel between loader, core and mover
// ~~~~~~~~~~~~~~~~~~~~
package complex_pkg;

    localparam int data_width = 32;
    localparam int register_count = 16;
    localparam int register_index_width = 4;
    localparam int n_constants = 3;
    localparam int constant_index_width = 2;
    localparam int program_depth = 8;
    localparam int program_index_width = 3;
    // Wide enough to hold a full program length of program_depth
    localparam int program_count_width = 4;
    localparam int n_channels = 2;
    localparam int channel_index_width = 1;
    localparam int control_address_width = 8;

    // Control address map, one address per word
    localparam logic [control_address_width-1:0] constant_value_base = 8'h00;
    localparam logic [control_address_width-1:0] constant_target_base = 8'h04;
    localparam logic [control_address_width-1:0] program_length_address = 8'h08;
    localparam logic [control_address_width-1:0] instruction_base = 8'h10;
    localparam logic [control_address_width-1:0] channel_source_base = 8'h20;

    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_mul,
        op_and
    } opcode_t;

    typedef struct packed {
        logic valid;
        logic [control_address_width-1:0] address;
        logic [data_width-1:0] data;
    } control_write_t;

    typedef struct packed {
        logic valid;
        logic [register_index_width-1:0] index;
        logic [data_width-1:0] value;
    } register_write_t;

    // Taken from the low 14 bits of a control write
    typedef struct packed {
        opcode_t opcode;
        logic [register_index_width-1:0] destination;
        logic [register_index_width-1:0] source_a;
        logic [register_index_width-1:0] source_b;
    } instruction_t;

    typedef struct packed {
        logic valid;
        logic [channel_index_width-1:0] channel;
        logic [data_width-1:0] value;
    } output_word_t;

    // True when address falls in the count words starting at base
    function automatic logic in_region(
        input logic [control_address_width-1:0] address,
        input logic [control_address_width-1:0] base,
        input int unsigned count
    );
        logic [control_address_width-1:0] offset;
        offset = address - base;
        return offset < count;
    endfunction

endpackage

// File: source/constant_loader.sv
// ~~~~~~~~~~~~~~~~~~~~
// Constant loader
// Replays the stored constants into the register file on
// start, lets them settle and then starts the core
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module constant_loader (
    input logic core_clock,
    input logic rst_n,
    input complex_pkg::control_write_t control,
    input logic start,
    input logic core_busy,
    input logic data_in_valid,
    output complex_pkg::register_write_t constant_write,
    output logic run
);

    typedef enum logic [1:0] {
        loader_idle,
        loader_write,
        loader_settle
    } loader_state_t;

    localparam logic [complex_pkg::constant_index_width-1:0] last_slot =
        complex_pkg::constant_index_width'(complex_pkg::n_constants - 1);

    logic [complex_pkg::data_width-1:0] constant_value [complex_pkg::n_constants];
    logic [complex_pkg::register_index_width-1:0] constant_target [complex_pkg::n_constants];
    logic [complex_pkg::control_address_width-1:0] value_offset;
    logic [complex_pkg::control_address_width-1:0] target_offset;
    logic [complex_pkg::constant_index_width-1:0] slot;
    logic settle_count;
    loader_state_t state;

    assign value_offset = control.address - complex_pkg::constant_value_base;
    assign target_offset = control.address - complex_pkg::constant_target_base;

    always_ff @(posedge core_clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < complex_pkg::n_constants; k++) begin
                constant_value[k] <= '0;
                constant_target[k] <= '0;
            end
        end else if (control.valid) begin
            if (complex_pkg::in_region(control.address, complex_pkg::constant_value_base,
                                       complex_pkg::n_constants)) begin
                constant_value[value_offset[complex_pkg::constant_index_width-1:0]] <=
                    control.data;
            end
            if (complex_pkg::in_region(control.address, complex_pkg::constant_target_base,
                                       complex_pkg::n_constants)) begin
                constant_target[target_offset[complex_pkg::constant_index_width-1:0]] <=
                    control.data[complex_pkg::register_index_width-1:0];
            end
        end
    end

    // A data_in write takes the register file port, so the slot is held for a cycle
    always_ff @(posedge core_clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= loader_idle;
            slot <= '0;
            settle_count <= 1'b0;
        end else begin
            case (state)
                loader_idle: begin
                    if (start && !core_busy) begin
                        state <= loader_write;
                        slot <= '0;
                    end
                end
                loader_write: begin
                    if (!data_in_valid) begin
                        if (slot == last_slot) begin
                            state <= loader_settle;
                            settle_count <= 1'b0;
                        end else begin
                            slot <= slot + 1'b1;
                        end
                    end
                end
                loader_settle: begin
                    settle_count <= 1'b1;
                    if (settle_count) begin
                        state <= loader_idle;
                    end
                end
                default: state <= loader_idle;
            endcase
        end
    end

    assign constant_write.valid = (state == loader_write) && !data_in_valid;
    assign constant_write.index = constant_target[slot];
    assign constant_write.value = constant_value[slot];

    // Second settle cycle
    assign run = (state == loader_settle) && settle_count;

endmodule

// File: source/compute_core.sv
// ~~~~~~~~~~~~~~~~~~~~
// Compute core
// Register file, instruction store and a single issue
// datapath that runs the program once per run strobe
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module compute_core (
    input logic core_clock,
    input logic rst_n,
    input complex_pkg::control_write_t control,
    input complex_pkg::register_write_t data_in,
    input complex_pkg::register_write_t constant_write,
    input logic run,
    output logic busy,
    output logic done,
    input logic [complex_pkg::register_index_width-1:0] read_index,
    output logic [complex_pkg::data_width-1:0] read_value
);

    localparam logic [complex_pkg::program_count_width-1:0] max_length =
        complex_pkg::program_count_width'(complex_pkg::program_depth);

    logic [complex_pkg::data_width-1:0] registers [complex_pkg::register_count];
    complex_pkg::instruction_t program_store [complex_pkg::program_depth];
    logic [complex_pkg::program_count_width-1:0] program_length;
    logic [complex_pkg::program_count_width-1:0] run_length;
    logic [complex_pkg::program_count_width-1:0] pc;
    logic [complex_pkg::control_address_width-1:0] instruction_offset;
    complex_pkg::instruction_t current;
    logic [complex_pkg::data_width-1:0] operand_a;
    logic [complex_pkg::data_width-1:0] operand_b;
    logic [complex_pkg::data_width-1:0] result;
    complex_pkg::register_write_t external_write;
    logic executing;

    assign instruction_offset = control.address - complex_pkg::instruction_base;

    always_ff @(posedge core_clock or negedge rst_n) begin
        if (!rst_n) begin
            program_length <= '0;
            for (int i = 0; i < complex_pkg::program_depth; i++) begin
                program_store[i] <= '0;
            end
        end else if (control.valid) begin
            if (control.address == complex_pkg::program_length_address) begin
                if (control.data > complex_pkg::program_depth) begin
                    program_length <= max_length;
                end else begin
                    program_length <= control.data[complex_pkg::program_count_width-1:0];
                end
            end
            if (complex_pkg::in_region(control.address, complex_pkg::instruction_base,
                                       complex_pkg::program_depth)) begin
                program_store[instruction_offset[complex_pkg::program_index_width-1:0]] <=
                    control.data[$bits(complex_pkg::instruction_t)-1:0];
            end
        end
    end

    // The length is captured at run so a late control write cannot stall the sequencer
    always_ff @(posedge core_clock or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            pc <= '0;
            run_length <= '0;
        end else if (!busy) begin
            if (run) begin
                busy <= 1'b1;
                pc <= '0;
                run_length <= program_length;
            end
        end else if (pc == run_length) begin
            busy <= 1'b0;
        end else begin
            pc <= pc + 1'b1;
        end
    end

    assign executing = busy && (pc != run_length);
    assign done = busy && (pc == run_length);

    assign current = program_store[pc[complex_pkg::program_index_width-1:0]];
    assign operand_a = registers[current.source_a];
    assign operand_b = registers[current.source_b];

    always_comb begin
        case (current.opcode)
            complex_pkg::op_add: result = operand_a + operand_b;
            complex_pkg::op_sub: result = operand_a - operand_b;
            // Only the low word of the product is kept
            complex_pkg::op_mul: result = operand_a * operand_b;
            default: result = operand_a & operand_b;
        endcase
    end

    // External data has priority over the constant loader
    assign external_write = data_in.valid ? data_in : constant_write;

    always_ff @(posedge core_clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < complex_pkg::register_count; r++) begin
                registers[r] <= '0;
            end
        end else if (executing) begin
            registers[current.destination] <= result;
        end else if (!busy && external_write.valid) begin
            registers[external_write.index] <= external_write.value;
        end
    end

    assign read_value = registers[read_index];

endmodule

// File: source/data_mover.sv
// ~~~~~~~~~~~~~~~~~~~~
// Data mover
// Reads the selected result registers after the core
// finishes and streams them out one channel per cycle
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module data_mover (
    input logic core_clock,
    input logic rst_n,
    input complex_pkg::control_write_t control,
    input logic start,
    output logic [complex_pkg::register_index_width-1:0] read_index,
    input logic [complex_pkg::data_width-1:0] read_value,
    output complex_pkg::output_word_t data_out,
    output logic done
);

    localparam logic [complex_pkg::channel_index_width-1:0] last_channel =
        complex_pkg::channel_index_width'(complex_pkg::n_channels - 1);

    logic [complex_pkg::register_index_width-1:0] channel_source [complex_pkg::n_channels];
    logic [complex_pkg::control_address_width-1:0] source_offset;
    logic [complex_pkg::channel_index_width-1:0] cursor;
    logic active;

    assign source_offset = control.address - complex_pkg::channel_source_base;

    always_ff @(posedge core_clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < complex_pkg::n_channels; c++) begin
                channel_source[c] <= '0;
            end
        end else if (control.valid && complex_pkg::in_region(control.address,
                     complex_pkg::channel_source_base, complex_pkg::n_channels)) begin
            channel_source[source_offset[complex_pkg::channel_index_width-1:0]] <=
                control.data[complex_pkg::register_index_width-1:0];
        end
    end

    // Cursor rests at channel 0, so the first read is already set up when start arrives
    assign read_index = channel_source[cursor];

    always_ff @(posedge core_clock or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            cursor <= '0;
            data_out <= '0;
            done <= 1'b0;
        end else begin
            done <= data_out.valid && (data_out.channel == last_channel);
            data_out.valid <= 1'b0;
            if (active || start) begin
                data_out.valid <= 1'b1;
                data_out.channel <= cursor;
                data_out.value <= read_value;
                if (cursor == last_channel) begin
                    active <= 1'b0;
                    cursor <= '0;
                end else begin
                    active <= 1'b1;
                    cursor <= cursor + 1'b1;
                end
            end
        end
    end

endmodule

// File: source/core_complex.sv
// ~~~~~~~~~~~~~~~~~~~~
// Core complex top level
// Constant loader, compute core and data mover sharing
// one control bus
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module core_complex (
    input logic core_clock,
    input logic rst_n,
    input complex_pkg::control_write_t control,
    input logic start,
    input complex_pkg::register_write_t data_in,
    output complex_pkg::output_word_t data_out,
    output logic done
);

    complex_pkg::register_write_t constant_write;
    logic run;
    logic core_busy;
    logic core_done;
    logic [complex_pkg::register_index_width-1:0] read_index;
    logic [complex_pkg::data_width-1:0] read_value;

    constant_loader loader (
        .core_clock(core_clock),
        .rst_n(rst_n),
        .control(control),
        .start(start),
        .core_busy(core_busy),
        .data_in_valid(data_in.valid),
        .constant_write(constant_write),
        .run(run)
    );

    compute_core core (
        .core_clock(core_clock),
        .rst_n(rst_n),
        .control(control),
        .data_in(data_in),
        .constant_write(constant_write),
        .run(run),
        .busy(core_busy),
        .done(core_done),
        .read_index(read_index),
        .read_value(read_value)
    );

    // The mover starts on the core's completion strobe
    data_mover mover (
        .core_clock(core_clock),
        .rst_n(rst_n),
        .control(control),
        .start(core_done),
        .read_index(read_index),
        .read_value(read_value),
        .data_out(data_out),
        .done(done)
    );

endmodule

// File: bench/core_complex_props.sv
// ~~~~~~~~~~~~~~~~~~~~
// Core complex timing properties
// Loader, core and mover strobe spacing, bound to the top
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module core_complex_props (
    input logic core_clock,
    input logic rst_n,
    input complex_pkg::control_write_t control,
    input logic start,
    input complex_pkg::register_write_t constant_write,
    input logic run,
    input logic core_busy,
    input logic core_done,
    input complex_pkg::output_word_t data_out,
    input logic done
);

    logic [1:0] constant_count;
    logic [3:0] length_shadow;
    logic [3:0] run_length;
    logic [4:0] elapsed;
    logic started;
    logic last_constant;

    // Every load writes all three constants, so a count modulo three marks the last one
    assign last_constant = constant_write.valid && constant_count == 2'd2;

    always_ff @(posedge core_clock or negedge rst_n) begin
        if (!rst_n) begin
            constant_count <= '0;
            length_shadow <= '0;
            run_length <= '0;
            elapsed <= '0;
            started <= 1'b0;
        end else begin
            if (constant_write.valid) begin
                constant_count <= last_constant ? 2'd0 : constant_count + 2'd1;
            end
            if (control.valid && control.address == 8'h08) begin
                length_shadow <= control.data > 32'd8 ? 4'd8 : control.data[3:0];
            end
            if (run && !core_busy) begin
                run_length <= length_shadow;
                elapsed <= 5'd1;
            end else if (core_done) begin
                elapsed <= '0;
            end else if (elapsed != '0) begin
                elapsed <= elapsed + 5'd1;
            end
            if (start) begin
                started <= 1'b1;
            end
        end
    end

    run_after_constants: assert property (@(posedge core_clock) disable iff (!rst_n)
        last_constant |-> ##2 run)
        else $error("run did not follow the last constant write by two cycles");

    run_needs_constants: assert property (@(posedge core_clock) disable iff (!rst_n)
        run |-> $past(last_constant, 2))
        else $error("run without a constant write two cycles before");

    core_done_timing: assert property (@(posedge core_clock) disable iff (!rst_n)
        core_done |-> elapsed != '0 && elapsed == 5'(run_length) + 5'd1)
        else $error("core_done not program length plus one cycles after run");

    core_done_due: assert property (@(posedge core_clock) disable iff (!rst_n)
        (elapsed != '0 && elapsed == 5'(run_length) + 5'd1) |-> core_done)
        else $error("core_done missing when the program should have finished");

    channel_sequence: assert property (@(posedge core_clock) disable iff (!rst_n)
        core_done |=> data_out.valid && data_out.channel == 1'b0
                      ##1 data_out.valid && data_out.channel == 1'b1
                      ##1 done && !data_out.valid)
        else $error("channel outputs and done out of sequence after core_done");

    done_needs_core_done: assert property (@(posedge core_clock) disable iff (!rst_n)
        done |-> $past(core_done, 3))
        else $error("done without a core_done three cycles before");

    quiet_until_start: assert property (@(posedge core_clock) disable iff (!rst_n)
        !started |-> !run && !core_done && !data_out.valid && !done)
        else $error("activity before the first start");

endmodule

bind core_complex core_complex_props props (
    .core_clock(core_clock),
    .rst_n(rst_n),
    .control(control),
    .start(start),
    .constant_write(constant_write),
    .run(run),
    .core_busy(core_busy),
    .core_done(core_done),
    .data_out(data_out),
    .done(done)
);

// File: bench/core_complex_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// Core complex testbench
// Random constants, programs and data words, checked
// against a shadow register file that runs the same program
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module core_complex_tb;

    localparam int rounds = 10;
    // The reset checks count as one more round
    localparam int cycle_limit = 40 * (rounds + 1);

    logic core_clock;
    logic rst_n;
    logic start;
    complex_pkg::control_write_t control;
    complex_pkg::register_write_t data_in;
    complex_pkg::output_word_t data_out;
    logic done;

    logic [31:0] lfsr_state = 32'h6dc64a49;
    logic [31:0] model_regs [16];
    logic [31:0] expected [2];
    logic outputs_allowed;
    int next_channel;
    int done_count;
    int cycles = 0;

    core_complex DUT (
        .core_clock(core_clock),
        .rst_n(rst_n),
        .control(control),
        .start(start),
        .data_in(data_in),
        .data_out(data_out),
        .done(done)
    );

    initial begin
        core_clock = 1'b0;
        forever #50 core_clock = ~core_clock;
    end

    always @(posedge core_clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    task automatic report_mismatch(input string message);
        $display("CHECK FAILED at %0t ns: %s", $time, message);
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped after a failed check");
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] random_bits(input int width);
        logic [31:0] value;
        value = '0;
        for (int b = 0; b < width; b++) begin
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] alu_result(input complex_pkg::opcode_t opcode,
                                               input logic [31:0] a, input logic [31:0] b);
        case (opcode)
            complex_pkg::op_add: return a + b;
            complex_pkg::op_sub: return a - b;
            complex_pkg::op_mul: return a * b;
            complex_pkg::op_and: return a & b;
            default: return '0;
        endcase
    endfunction

    // Called just after a falling edge; each write holds for one cycle
    task automatic write_control(input logic [7:0] address, input logic [31:0] data);
        control = '{valid: 1'b1, address: address, data: data};
        @(negedge core_clock);
        control.valid = 1'b0;
    endtask

    task automatic write_register(input logic [3:0] index, input logic [31:0] value);
        data_in = '{valid: 1'b1, index: index, value: value};
        @(negedge core_clock);
        data_in.valid = 1'b0;
        model_regs[index] = value;
    endtask

    always @(negedge core_clock) begin
        if (data_out.valid) begin
            assert (outputs_allowed && next_channel < 2 && data_out.channel == 1'(next_channel))
            else report_mismatch($sformatf("unexpected output on channel %0d", data_out.channel));
            assert (data_out.value == expected[data_out.channel])
            else report_mismatch($sformatf("channel %0d gave %h, expected %h",
                                           data_out.channel, data_out.value,
                                           expected[data_out.channel]));
            next_channel++;
        end
        if (done) begin
            assert (outputs_allowed && next_channel == 2)
            else report_mismatch("done without both channel outputs before it");
            done_count++;
        end
    end

    task automatic run_round(input int round);
        logic [31:0] constant_value [3];
        logic [3:0] constant_target [3];
        complex_pkg::instruction_t instructions [8];
        logic [3:0] source [2];
        logic [3:0] hit_index [3];
        logic [31:0] hit_value [3];
        logic [3:0] raw_length;
        logic [3:0] index;
        int length;
        int collisions;
        int first_done;
        logic busy_traffic;
        logic double_start;

        collisions = round % 4;
        busy_traffic = (round % 2) == 1;
        double_start = collisions >= 2;
        for (int k = 0; k < 3; k++) begin
            constant_value[k] = random_bits(32);
            constant_target[k] = 4'(random_bits(4));
            write_control(8'h00 + 8'(k), constant_value[k]);
            write_control(8'h04 + 8'(k), 32'(constant_target[k]));
        end
        raw_length = 4'(random_bits(4));
        length = raw_length > 8 ? 8 : int'(raw_length);
        write_control(8'h08, 32'(raw_length));
        for (int i = 0; i < length; i++) begin
            instructions[i] = complex_pkg::instruction_t'(14'(random_bits(14)));
            write_control(8'h10 + 8'(i), 32'(instructions[i]));
        end
        for (int c = 0; c < 2; c++) begin
            source[c] = 4'(random_bits(4));
            write_control(8'h20 + 8'(c), 32'(source[c]));
        end
        for (int j = 0; j < 2; j++) begin
            index = 4'(random_bits(4));
            write_register(index, random_bits(32));
        end

        // Colliding data_in words land first, then the constants, then the program runs
        for (int j = 0; j < collisions; j++) begin
            hit_index[j] = 4'(random_bits(4));
            hit_value[j] = random_bits(32);
            model_regs[hit_index[j]] = hit_value[j];
        end
        for (int k = 0; k < 3; k++) begin
            model_regs[constant_target[k]] = constant_value[k];
        end
        for (int i = 0; i < length; i++) begin
            model_regs[instructions[i].destination] =
                alu_result(instructions[i].opcode, model_regs[instructions[i].source_a],
                           model_regs[instructions[i].source_b]);
        end
        for (int c = 0; c < 2; c++) begin
            expected[c] = model_regs[source[c]];
        end
        next_channel = 0;
        outputs_allowed = 1'b1;
        first_done = done_count;

        start = 1'b1;
        @(negedge core_clock);
        start = 1'b0;
        for (int j = 0; j < collisions; j++) begin
            data_in = '{valid: 1'b1, index: hit_index[j], value: hit_value[j]};
            @(negedge core_clock);
        end
        data_in.valid = 1'b0;
        // A repeated start meets the loader while it writes slot 0, then the busy core
        start = double_start;
        while (!done) begin
            data_in.index = 4'(random_bits(4));
            data_in.value = random_bits(32);
            data_in.valid = busy_traffic && DUT.core_busy;
            @(negedge core_clock);
            start = double_start && DUT.core_busy;
        end
        start = 1'b0;
        data_in.valid = 1'b0;
        repeat (2) @(negedge core_clock);
        outputs_allowed = 1'b0;
        assert (done_count == first_done + 1)
        else report_mismatch($sformatf("round %0d gave %0d done strobes",
                                       round, done_count - first_done));
    endtask

    initial begin
        logic [3:0] warm_index;

        rst_n = 1'b0;
        start = 1'b0;
        control = '0;
        data_in = '0;
        outputs_allowed = 1'b0;
        next_channel = 0;
        done_count = 0;
        for (int r = 0; r < 16; r++) begin
            model_regs[r] = '0;
        end
        repeat (2) @(negedge core_clock);
        rst_n = 1'b1;

        // Traffic before the first start must leave the outputs quiet
        write_control(8'h20, 32'h5);
        write_control(8'h30, random_bits(32));
        for (int j = 0; j < 3; j++) begin
            warm_index = 4'(random_bits(4));
            write_register(warm_index, random_bits(32));
        end
        repeat (3) @(negedge core_clock);

        for (int round = 0; round < rounds; round++) begin
            run_round(round);
        end
        if (done_count == rounds) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("CHECK FAILED at %0t ns: %0d done strobes for %0d rounds",
                     $time, done_count, rounds);
            $display("=== FAIL ===");
            $fatal(1, "Simulation stopped after a failed check");
        end
    end

endmodule

// File: build.f
source/complex_pkg.sv
source/constant_loader.sv
source/compute_core.sv
source/data_mover.sv
source/core_complex.sv
bench/core_complex_props.sv
bench/core_complex_tb.sv

// File: Makefile
# Verilator build and run for the core complex testbench

TOP := core_complex_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f -o $(TOP)
	-./obj_dir/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG) || ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
